//--- common/dsm_pkg.sv
`default_nettype none

package dsm_pkg;

  // ####################
  // widths
  // ####################

  localparam int addr_w          = 48;
  localparam int qtd_w           = 32;
  localparam int tag_w           = 16;
  localparam int conf_id_w       = 32;
  localparam int line_w          = 512;
  localparam int queues_per_line = line_w / qtd_w;  // 16 counters per line

  // conf_valid code for a dsm word
  localparam int conf_type_dsm = 3;

  // ####################
  // bus payloads
  // ####################

  // 112 bits, base address in the top bits
  typedef struct packed {
    logic [addr_w-1:0]    base_addr;
    logic [qtd_w-1:0]     qtd_lines;
    logic [conf_id_w-1:0] conf_id;
  } conf_t;

  // one line write, 576 bits
  typedef struct packed {
    logic [line_w-1:0] data;
    logic [addr_w-1:0] addr;
    logic [tag_w-1:0]  tag;
  } wr_req_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
  } wr_ack_t;

  // msb set marks a status write, low bits carry the accelerator id
  function automatic logic [tag_w-1:0] dsm_tag(input int unsigned acc_id);
    logic [tag_w-1:0] tag;
    tag = {1'b1, acc_id[tag_w-2:0]};
    return tag;
  endfunction

endpackage

`default_nettype wire

//--- hdl/conf_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module conf_receiver #(
  parameter int CONF_ID = 1
) (
  input  wire                   clk,
  input  wire                   dsm_rst_internal,
  input  wire [1:0]             conf_valid,
  input  wire dsm_pkg::conf_t   conf,
  output logic                  conf_out_valid,
  output dsm_pkg::conf_t        conf_out
);

  logic type_match;
  logic id_match;
  logic accept;

  // ####################
  // filter
  // ####################

  assign type_match = (conf_valid == 2'(dsm_pkg::conf_type_dsm));
  assign id_match   = (conf.conf_id == dsm_pkg::conf_id_w'(CONF_ID));

  // words for other blocks or other accelerators fall through
  assign accept = type_match && id_match;

  // ####################
  // output register
  // ####################

  // single cycle strobe
  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      conf_out_valid <= 1'b0;
    end else begin
      conf_out_valid <= accept;
    end
  end

  // payload only moves on a hit
  always_ff @(posedge clk) begin
    if (accept) begin
      conf_out <= conf;
    end
  end

endmodule

`default_nettype wire

//--- hdl/queue_count_bank.sv
`timescale 1ns/10ps
`default_nettype none

module queue_count_bank #(
  parameter int NUM_INPUT_QUEUES  = 1,
  parameter int NUM_OUTPUT_QUEUES = 1
) (
  input  wire                           clk,
  input  wire                           dsm_rst_internal,
  input  wire [NUM_INPUT_QUEUES-1:0]    rd_en,
  input  wire [NUM_OUTPUT_QUEUES-1:0]   wr_en,
  output logic [(NUM_INPUT_QUEUES + dsm_pkg::queues_per_line - 1) / dsm_pkg::queues_per_line
                + (NUM_OUTPUT_QUEUES + dsm_pkg::queues_per_line - 1)
                / dsm_pkg::queues_per_line - 1:0][dsm_pkg::line_w-1:0] lines
);

  localparam int qpl = dsm_pkg::queues_per_line;
  localparam int qw  = dsm_pkg::qtd_w;

  localparam int rd_lines    = (NUM_INPUT_QUEUES + qpl - 1) / qpl;
  localparam int wr_lines    = (NUM_OUTPUT_QUEUES + qpl - 1) / qpl;
  localparam int total_lines = rd_lines + wr_lines;

  logic [NUM_INPUT_QUEUES-1:0][qw-1:0]  rd_count;
  logic [NUM_OUTPUT_QUEUES-1:0][qw-1:0] wr_count;
  logic [total_lines-1:0][dsm_pkg::line_w-1:0] packed_lines;

  // ####################
  // counters
  // ####################

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      rd_count <= '0;
      wr_count <= '0;
    end else begin
      for (int i = 0; i < NUM_INPUT_QUEUES; i++) begin
        if (rd_en[i]) begin
          rd_count[i] <= rd_count[i] + 1'b1;
        end
      end
      for (int i = 0; i < NUM_OUTPUT_QUEUES; i++) begin
        if (wr_en[i]) begin
          wr_count[i] <= wr_count[i] + 1'b1;
        end
      end
    end
  end

  // ####################
  // line packing
  // ####################

  // lane 0 in the low bits, unused lanes stay zero
  always_comb begin
    packed_lines = '0;
    for (int i = 0; i < NUM_INPUT_QUEUES; i++) begin
      packed_lines[i / qpl][(i % qpl) * qw +: qw] = rd_count[i];
    end
    // output queues follow the read lines
    for (int i = 0; i < NUM_OUTPUT_QUEUES; i++) begin
      packed_lines[rd_lines + i / qpl][(i % qpl) * qw +: qw] = wr_count[i];
    end
  end

  always_ff @(posedge clk) begin
    lines <= packed_lines;
  end

endmodule

`default_nettype wire

//--- dsm_controller/dsm_controller.sv
`timescale 1ns/10ps
`default_nettype none

module dsm_controller #(
  parameter int ACC_ID            = 1,
  parameter int NUM_INPUT_QUEUES  = 1,
  parameter int NUM_OUTPUT_QUEUES = 1
) (
  input  wire                          clk,
  input  wire                          dsm_rst_internal,
  input  wire                          start,
  input  wire                          conf_out_valid,
  input  wire dsm_pkg::conf_t          conf_out,
  input  wire [(NUM_INPUT_QUEUES + dsm_pkg::queues_per_line - 1) / dsm_pkg::queues_per_line
               + (NUM_OUTPUT_QUEUES + dsm_pkg::queues_per_line - 1)
               / dsm_pkg::queues_per_line - 1:0][dsm_pkg::line_w-1:0] lines,
  input  wire                          done_acc,
  input  wire [NUM_INPUT_QUEUES-1:0]   done_rd,
  input  wire [NUM_OUTPUT_QUEUES-1:0]  done_wr,
  input  wire                          available_write,
  input  wire dsm_pkg::wr_ack_t        write_ack,
  output logic                         request_write,
  output dsm_pkg::wr_req_t             write_data
);

  localparam int qpl = dsm_pkg::queues_per_line;

  localparam int rd_lines    = (NUM_INPUT_QUEUES + qpl - 1) / qpl;
  localparam int wr_lines    = (NUM_OUTPUT_QUEUES + qpl - 1) / qpl;
  localparam int total_lines = rd_lines + wr_lines;
  localparam int total_align = ((total_lines + 3) / 4) * 4;
  localparam int idx_w       = $clog2(total_align) + 1;

  localparam logic [1:0] s_idle  = 2'd0;
  localparam logic [1:0] s_lines = 2'd1;
  localparam logic [1:0] s_pad   = 2'd2;
  localparam logic [1:0] s_wait  = 2'd3;

  localparam logic [dsm_pkg::tag_w-1:0] my_tag = dsm_pkg::dsm_tag(ACC_ID);

  logic [1:0]                    state;
  logic [idx_w-1:0]              idx;
  logic [idx_w-1:0]              ack_count;
  logic [dsm_pkg::addr_w-1:0]    base_addr;
  logic [dsm_pkg::addr_w-1:0]    addr_next;
  logic                          conf_ready;
  logic                          send_done;
  logic [dsm_pkg::line_w-1:0]    done_now;
  logic [dsm_pkg::line_w-1:0]    done_word;
  logic [dsm_pkg::line_w-1:0]    done_last;
  logic                          update;
  logic                          ack_hit;
  logic                          round_acked;

  // ####################
  // configuration
  // ####################

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      base_addr  <= '0;
      conf_ready <= 1'b0;
    end else if (conf_out_valid) begin
      base_addr  <= conf_out.base_addr;
      conf_ready <= 1'b1;  // sticky until reset
    end
  end

  // ####################
  // done detection
  // ####################

  // bit 0 acc, then read queues, then write queues
  assign done_now = dsm_pkg::line_w'({done_wr, done_rd, done_acc});

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      done_word <= '0;
      update    <= 1'b0;
    end else begin
      done_word <= done_now;
      update    <= |(done_word & ~done_last);  // only newly raised bits
    end
  end

  // ####################
  // ack counting
  // ####################

  assign ack_hit     = write_ack.valid && (write_ack.tag == my_tag);
  assign round_acked = (state == s_wait) && (ack_count == idx_w'(total_align));

  // one ack covers four lines
  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      ack_count <= '0;
    end else if (start && round_acked) begin
      ack_count <= '0;
    end else if (ack_hit) begin
      ack_count <= ack_count + idx_w'(4);
    end
  end

  // ####################
  // write fsm
  // ####################

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      state         <= s_idle;
      request_write <= 1'b0;
      idx           <= '0;
      addr_next     <= '0;
      send_done     <= 1'b0;
      done_last     <= '0;
    end else begin
      request_write <= 1'b0;
      if (start) begin
        case (state)
          s_idle: begin
            if (update && conf_ready) begin
              done_last <= done_word;  // snapshot for the padding lines
              idx       <= '0;
              addr_next <= base_addr;
              send_done <= 1'b0;
              state     <= s_lines;
            end
          end
          s_lines: begin
            if (available_write) begin
              request_write <= 1'b1;
              idx           <= idx + 1'b1;
              addr_next     <= addr_next + 1'b1;
              // leave only once the last counter line went out
              if (idx == idx_w'(total_lines - 1)) begin
                state <= (total_lines == total_align) ? s_wait : s_pad;
              end
            end
          end
          s_pad: begin
            if (available_write) begin
              request_write <= 1'b1;
              idx           <= idx + 1'b1;
              addr_next     <= addr_next + 1'b1;
              if (idx == idx_w'(total_align - 1)) begin
                state <= s_wait;
              end
            end
          end
          s_wait: begin
            if (round_acked) begin
              if (send_done) begin
                send_done <= 1'b0;
                state     <= s_idle;
              end else begin
                // second round, padding now carries the done word
                idx       <= '0;
                addr_next <= base_addr;
                send_done <= 1'b1;
                state     <= s_lines;
              end
            end
          end
          default: state <= s_idle;
        endcase
      end
    end
  end

  // line payload, loaded with each issued request
  always_ff @(posedge clk) begin
    if (start && available_write && (state == s_lines || state == s_pad)) begin
      write_data.addr <= addr_next;
      write_data.tag  <= my_tag;
      if (state == s_lines) begin
        write_data.data <= lines[idx];
      end else if (send_done) begin
        write_data.data <= done_last;
      end else begin
        write_data.data <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dsm_top.sv
`timescale 1ns/10ps
`default_nettype none

module dsm_top #(
  parameter int ACC_ID            = 1,
  parameter int NUM_INPUT_QUEUES  = 1,
  parameter int NUM_OUTPUT_QUEUES = 1
) (
  input  wire                          clk,
  input  wire                          dsm_rst_internal,
  input  wire                          start,
  input  wire [1:0]                    conf_valid,
  input  wire dsm_pkg::conf_t          conf,
  input  wire                          done_acc,
  input  wire [NUM_INPUT_QUEUES-1:0]   done_rd,
  input  wire [NUM_OUTPUT_QUEUES-1:0]  done_wr,
  input  wire [NUM_INPUT_QUEUES-1:0]   acc_req_rd_data_en,
  input  wire [NUM_OUTPUT_QUEUES-1:0]  acc_req_wr_data_en,
  input  wire                          available_write,
  input  wire dsm_pkg::wr_ack_t        write_ack,
  output logic                         request_write,
  output dsm_pkg::wr_req_t             write_data
);

  localparam int qpl         = dsm_pkg::queues_per_line;
  localparam int total_lines = (NUM_INPUT_QUEUES + qpl - 1) / qpl
                               + (NUM_OUTPUT_QUEUES + qpl - 1) / qpl;

  logic                                         conf_out_valid;
  dsm_pkg::conf_t                               conf_out;
  logic [total_lines-1:0][dsm_pkg::line_w-1:0]  lines;

  conf_receiver #(
    .CONF_ID (ACC_ID)
  ) u_conf_receiver (
    .clk              (clk),
    .dsm_rst_internal (dsm_rst_internal),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .conf_out_valid   (conf_out_valid),
    .conf_out         (conf_out)
  );

  queue_count_bank #(
    .NUM_INPUT_QUEUES  (NUM_INPUT_QUEUES),
    .NUM_OUTPUT_QUEUES (NUM_OUTPUT_QUEUES)
  ) u_queue_count_bank (
    .clk              (clk),
    .dsm_rst_internal (dsm_rst_internal),
    .rd_en            (acc_req_rd_data_en),
    .wr_en            (acc_req_wr_data_en),
    .lines            (lines)
  );

  dsm_controller #(
    .ACC_ID            (ACC_ID),
    .NUM_INPUT_QUEUES  (NUM_INPUT_QUEUES),
    .NUM_OUTPUT_QUEUES (NUM_OUTPUT_QUEUES)
  ) u_dsm_controller (
    .clk              (clk),
    .dsm_rst_internal (dsm_rst_internal),
    .start            (start),
    .conf_out_valid   (conf_out_valid),
    .conf_out         (conf_out),
    .lines            (lines),
    .done_acc         (done_acc),
    .done_rd          (done_rd),
    .done_wr          (done_wr),
    .available_write  (available_write),
    .write_ack        (write_ack),
    .request_write    (request_write),
    .write_data       (write_data)
  );

endmodule

`default_nettype wire

//--- tests/dsm_assert.sv
`timescale 1ns/10ps
`default_nettype none

module dsm_assert #(
  parameter int TOTAL_ALIGN = 4
) (
  input wire                         clk,
  input wire                         dsm_rst_internal,
  input wire                         request_write,
  input wire                         available_write,
  input wire                         wait_state,  // waiting for acks
  input wire [dsm_pkg::addr_w-1:0]   req_addr,
  input wire [dsm_pkg::addr_w-1:0]   base_addr
);

  int fail_count = 0;

  // ####################
  // write port rules
  // ####################

  a_space_before_write: assert property (@(posedge clk) disable iff (dsm_rst_internal)
    request_write |-> $past(available_write))
    else begin
      $error("request_write without available_write the cycle before");
      fail_count++;
    end

  // only the last line of a round may still be on the port once the wait begins
  a_wait_only_last_line: assert property (@(posedge clk) disable iff (dsm_rst_internal)
    request_write && wait_state |->
      !$past(wait_state) && (req_addr == base_addr + TOTAL_ALIGN - 1))
    else begin
      $error("request_write during the ack wait");
      fail_count++;
    end

  a_addr_in_region: assert property (@(posedge clk) disable iff (dsm_rst_internal)
    request_write |-> (req_addr >= base_addr) && (req_addr < base_addr + TOTAL_ALIGN))
    else begin
      $error("write address outside the status region");
      fail_count++;
    end

endmodule

bind dsm_controller dsm_assert #(
  .TOTAL_ALIGN (total_align)
) u_dsm_assert (
  .clk              (clk),
  .dsm_rst_internal (dsm_rst_internal),
  .request_write    (request_write),
  .available_write  (available_write),
  .wait_state       (state == s_wait),
  .req_addr         (write_data.addr),
  .base_addr        (base_addr)
);

`default_nettype wire

//--- tests/tb_dsm.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dsm;

  localparam int acc_id       = 5;
  localparam int n_in         = 2;
  localparam int n_out        = 2;
  localparam int num_rows     = 10;
  localparam int max_cycles   = num_rows * 200;
  localparam int quiet_cycles = 16;  // covers the final ack and the return to idle

  typedef struct {
    string       name;
    bit          hold;   // keep the done level of the row before
    bit          start;
    logic [1:0]  ctype;
    logic [31:0] cid;
    logic [47:0] base;
    int          rd0, rd1, wr0, wr1;
    logic [4:0]  done;   // wr1 wr0 rd1 rd0 acc
    bit          rnd;
    int          exp_writes;
  } row_t;

  logic                       clk;
  logic                       dsm_rst_internal;
  logic                       start;
  logic [1:0]                 conf_valid;
  dsm_pkg::conf_t             conf;
  logic                       done_acc;
  logic [n_in-1:0]            done_rd;
  logic [n_out-1:0]           done_wr;
  logic [n_in-1:0]            acc_req_rd_data_en;
  logic [n_out-1:0]           acc_req_wr_data_en;
  logic                       available_write;
  dsm_pkg::wr_ack_t           write_ack;
  logic                       request_write;
  dsm_pkg::wr_req_t           write_data;

  row_t                       rows [num_rows];
  logic [dsm_pkg::line_w-1:0] rec_data [$];
  logic [dsm_pkg::addr_w-1:0] rec_addr [$];
  logic [dsm_pkg::tag_w-1:0]  rec_tag [$];
  int                         mem_lines;
  bit                         ack_due;
  logic [dsm_pkg::tag_w-1:0]  ack_tag;
  bit                         rand_avail;
  integer                     seed = 32'hc1a8c6d4;
  int                         rnd_word;
  int                         cycle_count;
  int                         exp_rd [n_in];
  int                         exp_wr [n_out];
  logic [dsm_pkg::addr_w-1:0] exp_base;
  int                         errors, row_errors, tests_failed, checks;
  int                         assert_fails;

  dsm_top #(
    .ACC_ID            (acc_id),
    .NUM_INPUT_QUEUES  (n_in),
    .NUM_OUTPUT_QUEUES (n_out)
  ) DUT (
    .clk                (clk),
    .dsm_rst_internal   (dsm_rst_internal),
    .start              (start),
    .conf_valid         (conf_valid),
    .conf               (conf),
    .done_acc           (done_acc),
    .done_rd            (done_rd),
    .done_wr            (done_wr),
    .acc_req_rd_data_en (acc_req_rd_data_en),
    .acc_req_wr_data_en (acc_req_wr_data_en),
    .available_write    (available_write),
    .write_ack          (write_ack),
    .request_write      (request_write),
    .write_data         (write_data)
  );

  always #20 clk = ~clk;

  // ####################
  // memory port model
  // ####################

  always @(negedge clk) begin
    if (!dsm_rst_internal && request_write) begin
      rec_data.push_back(write_data.data);
      rec_addr.push_back(write_data.addr);
      rec_tag.push_back(write_data.tag);
      mem_lines++;
      if (mem_lines % 4 == 0) begin
        ack_due = 1'b1;  // one ack per four lines
        ack_tag = write_data.tag;
      end
    end
  end

  always @(posedge clk) begin
    #2;
    write_ack.valid = ack_due;
    write_ack.tag   = ack_tag;
    ack_due         = 1'b0;
    if (rand_avail) begin
      rnd_word        = $random(seed);
      available_write = rnd_word[0];
    end else begin
      available_write = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  // ####################
  // helpers
  // ####################

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic set_row(input int i, input string name, input bit hold, input bit st,
                         input logic [1:0] ctype, input logic [31:0] cid,
                         input logic [47:0] base, input int r0, input int r1, input int w0,
                         input int w1, input logic [4:0] done, input bit rnd, input int exp_w);
    rows[i] = '{name, hold, st, ctype, cid, base, r0, r1, w0, w1, done, rnd, exp_w};
  endtask

  task automatic drive_done(input logic [4:0] d);
    done_acc = d[0];
    done_rd  = d[2:1];
    done_wr  = d[4:3];
  endtask

  task automatic send_conf(input logic [1:0] ctype, input logic [31:0] cid,
                           input logic [47:0] base);
    conf_valid     = ctype;
    conf.base_addr = base;
    conf.qtd_lines = 32'd4;
    conf.conf_id   = cid;
    next_cycle();
    conf_valid = 2'd0;
    next_cycle();
    if (ctype == 2'(dsm_pkg::conf_type_dsm) && cid == acc_id) begin
      exp_base = base;
    end
  endtask

  task automatic drive_counts(input int r0, input int r1, input int w0, input int w1);
    int n;
    n = r0;
    if (r1 > n) n = r1;
    if (w0 > n) n = w0;
    if (w1 > n) n = w1;
    for (int k = 0; k < n; k++) begin
      acc_req_rd_data_en = {k < r1, k < r0};
      acc_req_wr_data_en = {k < w1, k < w0};
      next_cycle();
    end
    acc_req_rd_data_en = '0;
    acc_req_wr_data_en = '0;
    exp_rd[0] += r0;
    exp_rd[1] += r1;
    exp_wr[0] += w0;
    exp_wr[1] += w1;
  endtask

  // line idx of a pass, round 0 pads with zeros, round 1 with the done word
  function automatic logic [dsm_pkg::line_w-1:0] expected_line(input int round, input int idx,
                                                              input logic [4:0] done);
    logic [dsm_pkg::line_w-1:0] line;
    line = '0;
    if (idx == 0) begin
      for (int q = 0; q < n_in; q++) begin
        line[q * dsm_pkg::qtd_w +: dsm_pkg::qtd_w] = exp_rd[q];
      end
    end else if (idx == 1) begin
      for (int q = 0; q < n_out; q++) begin
        line[q * dsm_pkg::qtd_w +: dsm_pkg::qtd_w] = exp_wr[q];
      end
    end else if (round == 1) begin
      line[4:0] = done;
    end
    return line;
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [dsm_pkg::line_w-1:0] exp_v,
                             input logic [dsm_pkg::line_w-1:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      row_errors++;
      $display("ERR %s %s expected %0h actual %0h", name, what, exp_v, act_v);
    end
  endtask

  task automatic run_row(input row_t r);
    int first;
    int got;
    row_errors = 0;
    first      = rec_data.size();
    if (!r.hold) begin
      drive_done(5'b0);
      wait_cycles(4);  // let the update flag fall before start moves
    end
    rand_avail = r.rnd;
    start      = r.start;
    send_conf(r.ctype, r.cid, r.base);
    drive_counts(r.rd0, r.rd1, r.wr0, r.wr1);
    wait_cycles(3);
    drive_done(r.done);
    while (rec_data.size() < first + r.exp_writes) begin
      next_cycle();
    end
    wait_cycles(quiet_cycles);
    got = rec_data.size() - first;
    checks++;
    if (got != r.exp_writes) begin
      errors++;
      row_errors++;
      $display("ERR %s writes expected %0d actual %0d", r.name, r.exp_writes, got);
    end
    for (int i = 0; i < got && i < r.exp_writes; i++) begin
      check_value(r.name, $sformatf("line %0d data", i),
                  expected_line(i / 4, i % 4, r.done), rec_data[first + i]);
      check_value(r.name, $sformatf("line %0d addr", i), exp_base + (i % 4), rec_addr[first + i]);
      check_value(r.name, $sformatf("line %0d tag", i),
                  {1'b1, 15'(acc_id)}, rec_tag[first + i]);
    end
    rand_avail = 1'b0;
    if (row_errors != 0) begin
      tests_failed++;
    end
    $display("test %-16s %s (%0d errors)", r.name, row_errors == 0 ? "ok" : "bad", row_errors);
  endtask

  // ####################
  // main
  // ####################

  initial begin
    clk                = 1'b0;
    dsm_rst_internal   = 1'b1;
    start              = 1'b0;
    conf_valid         = 2'd0;
    conf               = '0;
    drive_done(5'b0);
    acc_req_rd_data_en = '0;
    acc_req_wr_data_en = '0;
    available_write    = 1'b1;
    write_ack          = '0;
    ack_tag            = '0;
    exp_base           = '0;

    set_row(0, "reset_idle", 0, 0, 2'd0, 0, 48'h0, 1, 0, 0, 2, 5'b00001, 0, 0);
    set_row(1, "bad_type", 0, 1, 2'd2, 5, 48'h1000, 0, 0, 0, 0, 5'b00001, 0, 0);
    set_row(2, "bad_id", 0, 1, 2'd3, 6, 48'h1000, 0, 0, 0, 0, 5'b00001, 0, 0);
    set_row(3, "conf_start_low", 0, 0, 2'd3, 5, 48'h1000, 2, 1, 0, 0, 5'b00001, 0, 0);
    set_row(4, "first_pass", 0, 1, 2'd0, 0, 48'h0, 3, 1, 2, 5, 5'b00001, 0, 8);
    set_row(5, "done_hold", 1, 1, 2'd0, 0, 48'h0, 0, 0, 0, 0, 5'b00001, 0, 0);
    set_row(6, "done_drop", 1, 1, 2'd0, 0, 48'h0, 0, 0, 0, 0, 5'b00000, 0, 0);
    set_row(7, "new_bit", 1, 1, 2'd0, 0, 48'h0, 1, 1, 1, 1, 5'b00010, 0, 8);
    set_row(8, "rand_avail", 0, 1, 2'd0, 0, 48'h0, 4, 0, 3, 2, 5'b01100, 1, 8);
    set_row(9, "rand_reconf", 0, 1, 2'd3, 5, 48'h2_0000_0040, 0, 6, 1, 0, 5'b10001, 1, 8);

    repeat (5) @(posedge clk);
    #2;
    dsm_rst_internal = 1'b0;

    for (int i = 0; i < num_rows; i++) begin
      run_row(rows[i]);
    end

    assert_fails = DUT.u_dsm_controller.u_dsm_assert.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             num_rows, tests_failed, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
common/dsm_pkg.sv
hdl/conf_receiver.sv
hdl/queue_count_bank.sv
dsm_controller/dsm_controller.sv
hdl/dsm_top.sv
tests/dsm_assert.sv
tests/tb_dsm.sv

//--- Bender.yml
package:
  name: dsm_status

sources:
  # shared package first
  - files:
      - common/dsm_pkg.sv

  - files:
      - hdl/conf_receiver.sv
      - hdl/queue_count_bank.sv
      - dsm_controller/dsm_controller.sv
      - hdl/dsm_top.sv

  - target: test
    files:
      - tests/dsm_assert.sv
      - tests/tb_dsm.sv
